//--- compile.f
rtl/pcs_rx_pkg.sv
rtl/block_lock.sv
rtl/rx_descrambler.sv
rtl/ber_monitor.sv
rtl/pcs_rx_regs.sv
rtl/pcs_rx_top.sv
tests/pcs_rx_properties.sv
tests/tb_pcs_rx.sv

//--- rtl/ber_monitor.sv
// Counts invalid sync headers over fixed windows and raises high BER at each window end.
`timescale 1ns/1ns

module ber_monitor
    import pcs_rx_pkg::*;
#(
    parameter int BER_WINDOW = 256
) (
    input  logic phy_rx_clk,
    input  logic rst_n,
    input  logic hdr_err,
    output logic high_ber
);

    localparam int WIN_W = $clog2(BER_WINDOW);
    localparam int ERR_W = $clog2(BER_LIMIT + 1);

    logic [WIN_W-1:0] win_cnt;
    logic [ERR_W-1:0] err_cnt;
    logic [ERR_W-1:0] err_next;
    logic             win_end;

    assign win_end = win_cnt == WIN_W'(BER_WINDOW - 1);

    // Saturates at the limit.
    always_comb begin
        err_next = err_cnt;
        if (hdr_err && err_cnt != ERR_W'(BER_LIMIT)) begin
            err_next = err_cnt + 1'b1;
        end
    end

    always_ff @(posedge phy_rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt  <= '0;
            err_cnt  <= '0;
            high_ber <= 1'b0;
        end else begin
            if (win_end) begin
                win_cnt  <= '0;
                err_cnt  <= '0;
                high_ber <= err_next >= ERR_W'(BER_LIMIT);  // Last cycle counts too.
            end else begin
                win_cnt <= win_cnt + 1'b1;
                err_cnt <= err_next;
            end
        end
    end

endmodule

//--- rtl/block_lock.sv
// Checks 66-bit sync headers, pulses bitslip toward the SERDES until aligned and reports block lock.
`timescale 1ns/1ns

module block_lock
    import pcs_rx_pkg::*;
#(
    parameter int SLIP_WAIT  = 8,
    parameter int LOCK_COUNT = 64
) (
    input  logic         phy_rx_clk,
    input  logic         rst_n,
    input  serdes_word_t serdes_rx,
    input  logic         resync,
    output logic         bitslip,
    output rx_block_t    aligned,
    output logic         block_lock,
    output logic         hdr_err
);

    localparam int SLIP_W = $clog2(SLIP_WAIT + 1);
    localparam int GOOD_W = $clog2(LOCK_COUNT + 1);
    localparam int SPAN_W = $clog2(UNLOCK_SPAN);
    localparam int BAD_W  = $clog2(UNLOCK_LIMIT + 1);

    lock_state_e       state;
    logic [SLIP_W-1:0] slip_cnt;
    logic [GOOD_W-1:0] good_cnt;
    logic [SPAN_W-1:0] span_cnt;
    logic [BAD_W-1:0]  bad_cnt;
    serdes_word_t      word_q;
    logic              valid_q;
    logic              hdr_ok;
    logic              span_end;

    assign hdr_ok     = serdes_rx.hdr[1] ^ serdes_rx.hdr[0];  // 01 or 10.
    assign span_end   = span_cnt == SPAN_W'(UNLOCK_SPAN - 1);
    assign block_lock = state == LOCK_LOCKED;
    assign aligned    = '{valid: valid_q, hdr: word_q.hdr, data: word_q.data};

    always_ff @(posedge phy_rx_clk) begin
        word_q <= serdes_rx;
    end

    always_ff @(posedge phy_rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LOCK_HUNT;
            slip_cnt <= '0;
            good_cnt <= '0;
            span_cnt <= '0;
            bad_cnt  <= '0;
            bitslip  <= 1'b0;
            valid_q  <= 1'b0;
            hdr_err  <= 1'b0;
        end else begin
            bitslip <= 1'b0;
            valid_q <= state == LOCK_LOCKED;
            hdr_err <= (state == LOCK_LOCKED) && !hdr_ok;
            if (resync) begin
                state    <= LOCK_HUNT;
                good_cnt <= '0;
            end else begin
                case (state)
                    LOCK_HUNT: begin
                        if (!hdr_ok) begin
                            bitslip  <= 1'b1;
                            slip_cnt <= '0;
                            good_cnt <= '0;
                            state    <= LOCK_SLIP_WAIT;
                        end else if (good_cnt == GOOD_W'(LOCK_COUNT - 1)) begin
                            span_cnt <= '0;
                            bad_cnt  <= '0;
                            state    <= LOCK_LOCKED;
                        end else begin
                            good_cnt <= good_cnt + 1'b1;
                        end
                    end
                    LOCK_SLIP_WAIT: begin
                        // SERDES output is unsettled right after a slip.
                        if (slip_cnt == SLIP_W'(SLIP_WAIT - 1)) begin
                            state <= LOCK_HUNT;
                        end else begin
                            slip_cnt <= slip_cnt + 1'b1;
                        end
                    end
                    LOCK_LOCKED: begin
                        span_cnt <= span_end ? '0 : span_cnt + 1'b1;
                        if (span_end) begin
                            bad_cnt <= '0;
                        end else if (!hdr_ok) begin
                            bad_cnt <= bad_cnt + 1'b1;
                        end
                        if (!hdr_ok && bad_cnt == BAD_W'(UNLOCK_LIMIT - 1)) begin
                            good_cnt <= '0;
                            state    <= LOCK_HUNT;
                        end
                    end
                    default: state <= LOCK_HUNT;
                endcase
            end
        end
    end

endmodule

//--- rtl/pcs_rx_pkg.sv
// Shared types and IEEE constants of the 10GBASE-R receive PCS; imported by the RTL and testbench.
package pcs_rx_pkg;

    localparam int BER_LIMIT    = 16;  // Invalid headers per window that mean high BER.
    localparam int UNLOCK_LIMIT = 16;  // Invalid headers per span that drop lock.
    localparam int UNLOCK_SPAN  = 64;  // Headers per lock-loss span.

    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [1:0]  hdr;
        logic [63:0] data;
    } serdes_word_t;

    typedef struct packed {
        logic        valid;
        logic [1:0]  hdr;
        logic [63:0] data;
    } rx_block_t;

    typedef struct packed {
        logic block_lock;
        logic high_ber;
        logic hdr_err;  // One cycle per invalid header while locked.
    } pcs_rx_status_t;

    typedef struct packed {
        logic bypass;
        logic resync;  // One-cycle pulse.
    } pcs_rx_ctrl_t;

    typedef enum logic [1:0] {
        LOCK_HUNT      = 2'd0,
        LOCK_SLIP_WAIT = 2'd1,
        LOCK_LOCKED    = 2'd2
    } lock_state_e;

    typedef enum logic [AXI_ADDR_W-1:0] {
        REG_STATUS    = 8'h00,
        REG_ERR_COUNT = 8'h04,
        REG_CTRL      = 8'h08
    } reg_addr_e;

endpackage

//--- rtl/pcs_rx_regs.sv
// AXI4-Lite register block for PCS status, header error count, bypass and resync control.
`timescale 1ns/1ns

module pcs_rx_regs
    import pcs_rx_pkg::*;
(
    input  logic                    phy_rx_clk,
    input  logic                    rst_n,
    input  pcs_rx_status_t          status,
    output pcs_rx_ctrl_t            ctrl,
    input  logic [AXI_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [AXI_DATA_W-1:0]   wdata,
    input  logic [AXI_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [AXI_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [AXI_DATA_W-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    logic                  wr_fire;
    logic                  rd_fire;
    logic                  wr_hit;
    logic                  rd_hit;
    logic                  ctrl_wr;
    logic                  status_rd;
    logic                  count_rd;
    logic                  lock_q;
    logic                  lock_lost;
    logic [15:0]           err_count;
    logic [AXI_DATA_W-1:0] rd_word;

    // AW and W handshake in the same cycle only.
    assign awready = !bvalid && (wvalid || !awvalid);
    assign wready  = !bvalid && (awvalid || !wvalid);
    assign arready = !rvalid;

    assign wr_fire   = awvalid && wvalid && !bvalid;
    assign rd_fire   = arvalid && !rvalid;
    assign wr_hit    = awaddr inside {REG_STATUS, REG_ERR_COUNT, REG_CTRL};
    assign ctrl_wr   = wr_fire && awaddr == REG_CTRL && wstrb[0];
    assign status_rd = rd_fire && araddr == REG_STATUS;
    assign count_rd  = rd_fire && araddr == REG_ERR_COUNT;

    always_comb begin
        rd_hit = 1'b1;
        case (araddr)
            REG_STATUS: begin
                rd_word = AXI_DATA_W'({lock_lost, status.high_ber, status.block_lock});
            end
            REG_ERR_COUNT: rd_word = AXI_DATA_W'(err_count);
            REG_CTRL:      rd_word = AXI_DATA_W'(ctrl.bypass);  // Resync reads as 0.
            default: begin
                rd_word = '0;
                rd_hit  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge phy_rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            ctrl      <= '0;
            lock_q    <= 1'b0;
            lock_lost <= 1'b0;
            err_count <= '0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            ctrl.resync <= ctrl_wr && wdata[1];
            if (ctrl_wr) begin
                ctrl.bypass <= wdata[0];
            end

            // A fall in the read cycle wins over the clear.
            lock_q <= status.block_lock;
            if (lock_q && !status.block_lock) begin
                lock_lost <= 1'b1;
            end else if (status_rd) begin
                lock_lost <= 1'b0;
            end

            if (count_rd) begin
                err_count <= {15'd0, status.hdr_err};
            end else if (status.hdr_err && err_count != 16'hffff) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        if (wr_fire) begin
            bresp <= wr_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
    end

endmodule

//--- rtl/pcs_rx_top.sv
// Top of the 10GBASE-R receive PCS; takes SERDES words, returns aligned blocks and has AXI4-Lite.
`timescale 1ns/1ns

module pcs_rx_top
    import pcs_rx_pkg::*;
#(
    parameter int SLIP_WAIT  = 8,
    parameter int LOCK_COUNT = 64,
    parameter int BER_WINDOW = 256  // Cycles per BER window, 125 us on a real link.
) (
    input  logic                    phy_rx_clk,
    input  logic                    rst_n,
    input  serdes_word_t            serdes_rx,
    output logic                    bitslip,
    output rx_block_t               rx_block,
    input  logic [AXI_ADDR_W-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [AXI_DATA_W-1:0]   wdata,
    input  logic [AXI_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [AXI_ADDR_W-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [AXI_DATA_W-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    rx_block_t           aligned;
    wire pcs_rx_status_t status;
    pcs_rx_ctrl_t        ctrl;

    block_lock #(
        .SLIP_WAIT  (SLIP_WAIT),
        .LOCK_COUNT (LOCK_COUNT)
    ) u_block_lock (
        .phy_rx_clk (phy_rx_clk),
        .rst_n      (rst_n),
        .serdes_rx  (serdes_rx),
        .resync     (ctrl.resync),
        .bitslip    (bitslip),
        .aligned    (aligned),
        .block_lock (status.block_lock),
        .hdr_err    (status.hdr_err)
    );

    rx_descrambler u_rx_descrambler (
        .phy_rx_clk (phy_rx_clk),
        .rst_n      (rst_n),
        .aligned    (aligned),
        .bypass     (ctrl.bypass),
        .rx_block   (rx_block)
    );

    ber_monitor #(
        .BER_WINDOW (BER_WINDOW)
    ) u_ber_monitor (
        .phy_rx_clk (phy_rx_clk),
        .rst_n      (rst_n),
        .hdr_err    (status.hdr_err),
        .high_ber   (status.high_ber)
    );

    pcs_rx_regs u_pcs_rx_regs (
        .phy_rx_clk (phy_rx_clk),
        .rst_n      (rst_n),
        .status     (status),
        .ctrl       (ctrl),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

endmodule

//--- rtl/rx_descrambler.sv
// Self-synchronous x^58 + x^39 + 1 descrambler for aligned blocks, with a bypass for raw data.
`timescale 1ns/1ns

module rx_descrambler
    import pcs_rx_pkg::*;
(
    input  logic      phy_rx_clk,
    input  logic      rst_n,
    input  rx_block_t aligned,
    input  logic      bypass,
    output rx_block_t rx_block
);

    logic [57:0] hist;       // Bit 0 is the most recent scrambled bit.
    logic [57:0] hist_next;
    logic [63:0] plain;
    logic        valid_q;
    logic [1:0]  hdr_q;
    logic [63:0] data_q;

    // Bit 0 of the payload is first on the line.
    always_comb begin
        hist_next = hist;
        for (int i = 0; i < 64; i++) begin
            plain[i]  = aligned.data[i] ^ hist_next[38] ^ hist_next[57];
            hist_next = {hist_next[56:0], aligned.data[i]};
        end
    end

    always_ff @(posedge phy_rx_clk) begin
        hist   <= hist_next;  // Runs while unlocked too.
        hdr_q  <= aligned.hdr;
        data_q <= bypass ? aligned.data : plain;
    end

    always_ff @(posedge phy_rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= aligned.valid;
        end
    end

    assign rx_block = '{valid: valid_q, hdr: hdr_q, data: data_q};

endmodule

//--- run.sh
#!/bin/sh
# Builds the PCS receive testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_pcs_rx -o sim_pcs_rx
if ./obj_dir/sim_pcs_rx | tee /dev/stderr | grep "PASS: all tests" > /dev/null; then
    exit 0
else
    exit 1
fi

//--- tests/pcs_rx_properties.sv
// Concurrent assertions on lock, output validity and the AXI write response; bound into the PCS top.
`timescale 1ns/1ns

module pcs_rx_properties (
    input logic phy_rx_clk,
    input logic rst_n,
    input logic block_lock,
    input logic bitslip,
    input logic rx_valid,
    input logic bvalid,
    input logic bready
);

    int fail_count = 0;

    // A locked aligner never asks the SERDES to slip.
    no_slip_locked: assert property (@(posedge phy_rx_clk) disable iff (!rst_n)
        !(block_lock && bitslip))
        else begin
            fail_count++;
            $error("bitslip pulsed while block lock was high");
        end

    valid_after_lock: assert property (@(posedge phy_rx_clk) disable iff (!rst_n)
        rx_valid |-> $past(block_lock, 2))
        else begin
            fail_count++;
            $error("rx_block.valid without block lock two cycles earlier");
        end

    bresp_hold: assert property (@(posedge phy_rx_clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

endmodule

//--- tests/tb_pcs_rx.sv
// Testbench for the PCS receive top; models a slipping SERDES stream and checks data and registers.
`timescale 1ns/1ns

module tb_pcs_rx
    import pcs_rx_pkg::*;
();

    localparam int NBLK    = 20600;
    localparam int TIMEOUT = 20000;  // About 4000 cycles are needed.

    logic                  phy_rx_clk;
    logic                  rst_n;
    serdes_word_t          serdes_rx;
    logic                  bitslip;
    rx_block_t             rx_block;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    logic [1:0]  hdr_arr [NBLK];
    logic [63:0] scr_arr [NBLK];  // Scrambled payload as sent on the line.
    int          pos;             // Bit offset of the window in the stream.
    int          cycles;
    int          errors;
    int          checks;
    int          cmp_cnt;
    int          exp_idx;
    bit          synced;
    bit          check_en;
    bit          bypass_mode;

    pcs_rx_top UUT (.*);

    bind pcs_rx_top pcs_rx_properties u_properties (
        .phy_rx_clk (phy_rx_clk),
        .rst_n      (rst_n),
        .block_lock (status.block_lock),
        .bitslip    (bitslip),
        .rx_valid   (rx_block.valid),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    always #5 phy_rx_clk = ~phy_rx_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // History bit 0 is the last line bit of the previous block.
    function automatic logic [63:0] scramble_block(input logic [63:0] plain,
                                                   input logic [63:0] prev);
        logic [57:0] s;
        logic [63:0] out;
        for (int k = 0; k < 58; k++) begin
            s[k] = prev[63-k];
        end
        for (int i = 0; i < 64; i++) begin
            out[i] = plain[i] ^ s[38] ^ s[57];
            s      = {s[56:0], out[i]};
        end
        return out;
    endfunction

    function automatic logic [63:0] descramble_block(input logic [63:0] scr,
                                                     input logic [63:0] prev);
        logic [57:0] s;
        logic [63:0] out;
        for (int k = 0; k < 58; k++) begin
            s[k] = prev[63-k];
        end
        for (int i = 0; i < 64; i++) begin
            out[i] = scr[i] ^ s[38] ^ s[57];
            s      = {s[56:0], scr[i]};
        end
        return out;
    endfunction

    // Line order per block is hdr[0], hdr[1], then data bit 0 upward.
    function automatic serdes_word_t window_at(input int p);
        logic [65:0] w;
        int          n;
        int          b;
        int          r;
        for (int q = 0; q < 66; q++) begin
            n = p + q;
            b = n / 66;
            r = n % 66;
            w[q] = (r < 2) ? hdr_arr[b][r[0]] : scr_arr[b][6'(r - 2)];
        end
        return '{hdr: w[1:0], data: w[65:2]};
    endfunction

    function automatic logic [65:0] expected_block(input int n);
        if (bypass_mode) begin
            return {hdr_arr[n], scr_arr[n]};
        end
        return {hdr_arr[n], descramble_block(scr_arr[n], scr_arr[n-1])};
    endfunction

    task automatic check_value(input string name, input logic [65:0] exp, input logic [65:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // SERDES model; a bitslip moves the window one bit later.
    always @(negedge phy_rx_clk) begin
        if (rst_n) begin
            if (bitslip) begin
                pos = pos + 1;
            end
            pos = pos + 66;
        end
        serdes_rx <= window_at(pos);
    end

    // Pairs each valid output with the next sent block.
    always @(negedge phy_rx_clk) begin
        int lo;
        int hi;
        if (!rst_n || !rx_block.valid) begin
            synced = 1'b0;
        end else begin
            if (!synced) begin
                lo = (pos / 66 > 7) ? pos / 66 - 6 : 1;
                hi = pos / 66 + 1;
                for (int n = lo; n <= hi; n++) begin
                    if (!synced && expected_block(n) === {rx_block.hdr, rx_block.data}) begin
                        synced  = 1'b1;
                        exp_idx = n;
                    end
                end
                if (!synced && check_en) begin
                    errors++;
                    $display("received block %h matches no sent block", rx_block.data);
                end
            end
            if (synced) begin
                if (check_en) begin
                    check_value("rx_block", expected_block(exp_idx),
                                {rx_block.hdr, rx_block.data});
                    cmp_cnt++;
                end
                exp_idx++;
            end
        end
    end

    always @(posedge phy_rx_clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int hold,
                             output logic [1:0] resp);
        @(negedge phy_rx_clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        while (!(awready && wready)) @(negedge phy_rx_clk);
        @(negedge phy_rx_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge phy_rx_clk);
        resp = bresp;
        repeat (hold) begin  // Response held under back-pressure.
            @(negedge phy_rx_clk);
            check_value("ready under back-pressure", 66'b00, 66'({awready, wready}));
        end
        bready = 1'b1;
        @(negedge phy_rx_clk);
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge phy_rx_clk);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge phy_rx_clk);
        @(negedge phy_rx_clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge phy_rx_clk);
        data = rdata;
        resp = rresp;
        @(negedge phy_rx_clk);
    endtask

    task automatic wait_lock();
        logic [31:0] d;
        logic [1:0]  r;
        int          tries;
        tries = 0;
        do begin
            repeat (10) @(negedge phy_rx_clk);
            axi_read(REG_STATUS, d, r);
            tries++;
        end while (!d[0] && tries < 300);
        if (!d[0]) begin
            errors++;
            $display("block lock was not reached");
        end
    endtask

    task automatic corrupt_headers(input int count, input int spacing);
        int base;
        @(posedge phy_rx_clk);
        base = pos / 66 + 4;
        for (int j = 0; j < count; j++) begin
            hdr_arr[base + j * spacing] = 2'b00;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    initial begin
        logic [31:0] rng;
        logic [63:0] plain;
        logic [63:0] prev;
        logic [31:0] d;
        logic [1:0]  resp;
        int          err0;
        int          cmp0;
        phy_rx_clk = 1'b0;
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        cycles = 0;
        errors = 0;
        checks = 0;
        cmp_cnt = 0;
        exp_idx = 0;
        synced = 1'b0;
        check_en = 1'b0;
        bypass_mode = 1'b0;
        pos = 17;
        rng = 32'hc3bd336d;
        prev = '0;
        for (int n = 0; n < NBLK; n++) begin
            rng = xorshift(rng);
            plain[31:0] = rng;
            rng = xorshift(rng);
            plain[63:32] = rng;
            hdr_arr[n] = rng[0] ? 2'b01 : 2'b10;
            scr_arr[n] = scramble_block(plain, prev);
            prev = scr_arr[n];
        end
        serdes_rx = window_at(pos);
        repeat (4) @(posedge phy_rx_clk);
        @(negedge phy_rx_clk);
        rst_n = 1'b1;

        err0 = errors;
        // Order is bitslip, valid, bvalid, rvalid, awready, wready, arready.
        check_value("reset outputs", 66'b000_0111,
                    66'({bitslip, rx_block.valid, bvalid, rvalid, awready, wready, arready}));
        wait_lock();
        axi_read(REG_STATUS, d, resp);
        check_value("align status lock", 66'd1, 66'(d[0]));
        check_en = 1'b1;
        cmp0 = cmp_cnt;
        repeat (300) @(negedge phy_rx_clk);
        check_value("align blocks compared", 66'd1, 66'(cmp_cnt - cmp0 > 250));
        report_test("alignment", err0);

        err0 = errors;
        check_en = 1'b0;
        axi_write(REG_CTRL, 32'h1, 0, resp);
        check_value("bypass write resp", 66'(AXI_RESP_OKAY), 66'(resp));
        repeat (4) @(negedge phy_rx_clk);
        bypass_mode = 1'b1;
        check_en = 1'b1;
        cmp0 = cmp_cnt;
        repeat (200) @(negedge phy_rx_clk);
        check_value("bypass blocks compared", 66'd1, 66'(cmp_cnt - cmp0 > 150));
        check_en = 1'b0;
        axi_write(REG_CTRL, 32'h0, 0, resp);
        repeat (4) @(negedge phy_rx_clk);
        bypass_mode = 1'b0;
        check_en = 1'b1;
        repeat (100) @(negedge phy_rx_clk);
        report_test("bypass", err0);

        err0 = errors;
        axi_read(REG_ERR_COUNT, d, resp);
        corrupt_headers(5, 8);
        repeat (60) @(negedge phy_rx_clk);
        axi_read(REG_ERR_COUNT, d, resp);
        check_value("err count", 66'd5, 66'(d));
        axi_read(REG_ERR_COUNT, d, resp);
        check_value("err count cleared", 66'd0, 66'(d));
        axi_read(REG_STATUS, d, resp);
        check_value("lock held", 66'd1, 66'(d[0]));
        report_test("error counting", err0);

        err0 = errors;
        corrupt_headers(64, 8);
        repeat (510) @(negedge phy_rx_clk);
        axi_read(REG_STATUS, d, resp);
        check_value("high ber set", 66'd1, 66'(d[1]));
        repeat (560) @(negedge phy_rx_clk);
        axi_read(REG_STATUS, d, resp);
        check_value("high ber cleared", 66'd0, 66'(d[1]));
        report_test("high ber", err0);

        err0 = errors;
        axi_read(REG_STATUS, d, resp);
        axi_write(REG_CTRL, 32'h2, 0, resp);
        repeat (4) @(negedge phy_rx_clk);
        axi_read(REG_STATUS, d, resp);
        check_value("resync lock lost", 66'b100, 66'(d[2:0]));
        axi_read(REG_STATUS, d, resp);
        check_value("lock lost cleared", 66'd0, 66'(d[2]));
        axi_read(REG_CTRL, d, resp);
        check_value("ctrl readback", 66'd0, 66'(d));
        wait_lock();
        axi_read(REG_STATUS, d, resp);
        check_value("relocked status", 66'b001, 66'(d[2:0]));
        axi_write(REG_STATUS, 32'hffffffff, 3, resp);
        check_value("status write resp", 66'(AXI_RESP_OKAY), 66'(resp));
        axi_read(REG_STATUS, d, resp);
        check_value("status unchanged", 66'd1, 66'(d));
        axi_read(8'h10, d, resp);
        check_value("unmapped read resp", 66'(AXI_RESP_SLVERR), 66'(resp));
        report_test("resync and axi", err0);

        errors = errors + UUT.u_properties.fail_count;
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
